//--- ctrl_exc_cause.sv
// synchronous exception ranker
// picks the highest ranked exception of the decode-stage instruction
// or the last load/store, and forms cause code and trap value
module ctrl_exc_cause (
  input  ctrl_pkg::decode_info_t      dec_i,
  input  logic                        load_err_i,   // registered
  input  logic                        store_err_i,  // registered
  input  logic [ctrl_pkg::XLEN-1:0]   lsu_addr_i,   // last lsu address
  output logic                        exc_req_o,
  output ctrl_pkg::exc_cause_e        exc_cause_o,
  output logic [ctrl_pkg::XLEN-1:0]   exc_mtval_o
);

  logic [ctrl_pkg::XLEN-1:0] instr_val;  // faulting instr for mtval

  assign exc_req_o = dec_i.fetch_err | dec_i.illegal | dec_i.ecall | dec_i.ebrk |
                     store_err_i | load_err_i;

  // compressed instr zero extended
  assign instr_val = dec_i.is_compressed ?
                     {{(ctrl_pkg::XLEN - ctrl_pkg::ILEN_C){1'b0}}, dec_i.instr_c} :
                     dec_i.instr;

  ////////////////////////////////////////////////////////////////////
  // priority: fetch, illegal, ecall, ebreak, store, load
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    exc_cause_o = ctrl_pkg::exc_cause_e'(6'd0);
    exc_mtval_o = '0;
    if (dec_i.fetch_err) begin
      exc_cause_o = ctrl_pkg::INSTR_ACCESS_FAULT;
      exc_mtval_o = dec_i.pc;                      // faulting fetch address
    end else if (dec_i.illegal) begin
      exc_cause_o = ctrl_pkg::ILLEGAL_INSN;
      exc_mtval_o = instr_val;
    end else if (dec_i.ecall) begin
      exc_cause_o = ctrl_pkg::ECALL_MMODE;         // mtval stays zero
    end else if (dec_i.ebrk) begin
      exc_cause_o = ctrl_pkg::BREAKPOINT;          // mtval stays zero
    end else if (store_err_i) begin
      exc_cause_o = ctrl_pkg::STORE_ACCESS_FAULT;
      exc_mtval_o = lsu_addr_i;
    end else if (load_err_i) begin
      exc_cause_o = ctrl_pkg::LOAD_ACCESS_FAULT;
      exc_mtval_o = lsu_addr_i;
    end
  end

endmodule

//--- ctrl_fsm.sv
// controller state machine
// boot, decode, flush, irq entry and wfi sleep, with the nmi mode
// and lsu error registers, stall/halt logic and pc/csr commands
module ctrl_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_enable_i,
  input  logic                      instr_valid_i,
  input  ctrl_pkg::decode_info_t    dec_i,
  input  logic                      stall_i,
  input  logic                      branch_i,
  input  logic                      jump_i,
  input  logic                      load_err_i,   // one-cycle pulse
  input  logic                      store_err_i,  // one-cycle pulse
  input  logic                      any_irq_i,    // wake-up, ignores mie
  input  logic                      take_irq_i,
  input  ctrl_pkg::exc_cause_e      irq_cause_i,
  input  logic                      exc_req_i,
  input  ctrl_pkg::exc_cause_e      exc_cause_i,
  input  logic [ctrl_pkg::XLEN-1:0] exc_mtval_i,
  output logic                      nmi_mode_o,
  output logic                      load_err_q_o,
  output logic                      store_err_q_o,
  output ctrl_pkg::pc_ctrl_t        pc_o,
  output ctrl_pkg::csr_ctrl_t       csr_o,
  output logic                      instr_req_o,
  output logic                      busy_o,
  output logic                      first_fetch_o,
  output logic                      id_ready_o,
  output logic                      instr_clear_o
);

  ctrl_pkg::ctrl_state_e state_q, state_d;

  logic nmi_mode_q, nmi_mode_d;
  logic load_err_q;
  logic store_err_q;

  logic halt_if;      // hold fetch
  logic halt_id;      // kill decode instr
  logic special_req;  // needs a flush

  // mret, wfi, exceptions incl. lsu errors of this cycle
  assign special_req = instr_valid_i &
                       (dec_i.mret | dec_i.wfi | exc_req_i | load_err_i | store_err_i);

  ////////////////////////////////////////////////////////////////////
  // next state and commands
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    nmi_mode_d    = nmi_mode_q;
    instr_req_o   = 1'b1;
    busy_o        = 1'b1;
    first_fetch_o = 1'b0;
    halt_if       = 1'b0;
    halt_id       = 1'b0;
    pc_o.set      = 1'b0;
    pc_o.sel      = ctrl_pkg::PC_BOOT;
    pc_o.exc_sel  = ctrl_pkg::EXC_PC_EXC;
    csr_o         = '0;

    unique case (state_q)
      ctrl_pkg::RESET: begin
        instr_req_o = 1'b0;              // idle until enabled
        pc_o.set    = 1'b1;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::BOOT_SET;
        end
      end

      ctrl_pkg::BOOT_SET: begin
        pc_o.set = 1'b1;                 // boot address to fetch
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      ctrl_pkg::FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (!stall_i) begin
          state_d = ctrl_pkg::DECODE;
        end
        // pipe is empty here, irq can go straight in
        if (take_irq_i && !stall_i) begin
          state_d = ctrl_pkg::IRQ_TAKEN;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end
      end

      ctrl_pkg::DECODE: begin
        if (instr_valid_i) begin
          if (branch_i || jump_i) begin
            pc_o.set = 1'b1;             // redirect same cycle
            pc_o.sel = ctrl_pkg::PC_JUMP;
          end else if (special_req && !stall_i) begin
            state_d = ctrl_pkg::FLUSH;
            halt_if = 1'b1;
            halt_id = 1'b1;
          end
        end
        if (!stall_i && !special_req && take_irq_i) begin
          state_d = ctrl_pkg::IRQ_TAKEN;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end
      end

      ctrl_pkg::IRQ_TAKEN: begin
        if (take_irq_i) begin
          pc_o.set         = 1'b1;
          pc_o.sel         = ctrl_pkg::PC_EXC;
          pc_o.exc_sel     = ctrl_pkg::EXC_PC_IRQ;
          csr_o.save_if    = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.cause      = irq_cause_i;
          if (irq_cause_i == ctrl_pkg::IRQ_NM) begin
            nmi_mode_d = 1'b1;           // enter nmi handler
          end
        end
        state_d = ctrl_pkg::DECODE;
      end

      ctrl_pkg::FLUSH: begin
        halt_if = 1'b1;
        halt_id = 1'b1;
        state_d = ctrl_pkg::DECODE;
        // lsu errors were only high in DECODE, use the registered copy
        if (exc_req_i) begin
          pc_o.set         = 1'b1;
          pc_o.sel         = ctrl_pkg::PC_EXC;
          csr_o.save_id    = 1'b1;
          csr_o.save_cause = 1'b1;
          csr_o.cause      = exc_cause_i;
          csr_o.mtval      = exc_mtval_i;
        end else if (dec_i.mret) begin
          pc_o.set           = 1'b1;
          pc_o.sel           = ctrl_pkg::PC_ERET;
          csr_o.restore_mret = 1'b1;
          nmi_mode_d         = 1'b0;     // leave nmi handler
        end else if (dec_i.wfi) begin
          state_d = ctrl_pkg::WAIT_SLEEP;
        end
      end

      ctrl_pkg::WAIT_SLEEP: begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        state_d     = ctrl_pkg::SLEEP;
      end

      ctrl_pkg::SLEEP: begin
        busy_o      = 1'b0;              // clock gate may kick in
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        if (any_irq_i) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // handshake with IF/ID register
  ////////////////////////////////////////////////////////////////////

  assign id_ready_o    = ~stall_i & ~halt_if;
  assign instr_clear_o = ~stall_i | halt_id;  // drop done or flushed instr

  assign nmi_mode_o    = nmi_mode_q;
  assign load_err_q_o  = load_err_q;
  assign store_err_q_o = store_err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ctrl_pkg::RESET;
      nmi_mode_q  <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      nmi_mode_q  <= nmi_mode_d;
      load_err_q  <= load_err_i;     // seen by FLUSH
      store_err_q <= store_err_i;
    end
  end

endmodule

//--- ctrl_irq_arbiter.sv
// interrupt arbiter
// decides whether an interrupt is taken and ranks the pending
// sources: nmi, highest fast line, external, software, timer
module ctrl_irq_arbiter #(
  parameter int unsigned NUM_FAST_IRQ = 15
) (
  input  ctrl_pkg::irq_info_t  irq_i,
  input  logic                 nmi_mode_i,  // already in nmi handler
  output logic                 take_irq_o,
  output ctrl_pkg::exc_cause_e irq_cause_o
);

  localparam int unsigned FAST_IDX_W = $clog2(ctrl_pkg::MAX_FAST_IRQ);

  logic [ctrl_pkg::MAX_FAST_IRQ-1:0] fast_pend;  // implemented lines only
  logic [FAST_IDX_W-1:0]             fast_idx;
  logic                              nmi_req;
  logic                              maskable;

  assign fast_pend = irq_i.fast & ctrl_pkg::fast_mask(NUM_FAST_IRQ);

  // nmi is not nested
  assign nmi_req  = irq_i.nmi & ~nmi_mode_i;
  assign maskable = irq_i.msip | irq_i.mtip | irq_i.meip | (|fast_pend);

  assign take_irq_o = nmi_req | (maskable & irq_i.mie);

  ////////////////////////////////////////////////////////////////////
  // fast line select, highest index wins
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    fast_idx = '0;
    for (int unsigned i = 0; i < ctrl_pkg::MAX_FAST_IRQ; i++) begin
      if (fast_pend[i]) begin
        fast_idx = FAST_IDX_W'(i);  // later lines override
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // cause ranking
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    if (nmi_req) begin
      irq_cause_o = ctrl_pkg::IRQ_NM;
    end else if (|fast_pend) begin
      // 32 + 16 + n
      irq_cause_o = ctrl_pkg::exc_cause_e'({2'b11, fast_idx});
    end else if (irq_i.meip) begin
      irq_cause_o = ctrl_pkg::IRQ_EXTERNAL_M;
    end else if (irq_i.msip) begin
      irq_cause_o = ctrl_pkg::IRQ_SOFTWARE_M;
    end else begin
      irq_cause_o = ctrl_pkg::IRQ_TIMER_M;  // timer or nothing pending
    end
  end

endmodule

//--- ctrl_pkg.sv
// controller package
// shared widths, state and cause encodings, and the bundles that
// travel between the decode-stage controller blocks
package ctrl_pkg;

  localparam int unsigned XLEN         = 32;  // data / address width
  localparam int unsigned ILEN_C       = 16;  // compressed instr width
  localparam int unsigned MAX_FAST_IRQ = 16;  // fast irq lines supported

  ////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN,
    WAIT_SLEEP,
    SLEEP
  } ctrl_state_e;

  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  // msb set for interrupts, fast line n sits at 32+16+n
  typedef enum logic [5:0] {
    INSTR_ACCESS_FAULT = 6'd1,
    ILLEGAL_INSN       = 6'd2,
    BREAKPOINT         = 6'd3,
    LOAD_ACCESS_FAULT  = 6'd5,
    STORE_ACCESS_FAULT = 6'd7,
    ECALL_MMODE        = 6'd11,
    IRQ_SOFTWARE_M     = 6'd35,
    IRQ_TIMER_M        = 6'd39,
    IRQ_EXTERNAL_M     = 6'd43,
    IRQ_NM             = 6'd63
  } exc_cause_e;

  ////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              illegal;
    logic              ecall;
    logic              ebrk;
    logic              mret;
    logic              wfi;
    logic              fetch_err;
    logic              is_compressed;
    logic [XLEN-1:0]   instr;
    logic [ILEN_C-1:0] instr_c;
    logic [XLEN-1:0]   pc;
  } decode_info_t;

  typedef struct packed {
    logic                    nmi;
    logic                    msip;  // software
    logic                    mtip;  // timer
    logic                    meip;  // external
    logic                    mie;   // global machine irq enable
    logic [MAX_FAST_IRQ-1:0] fast;
  } irq_info_t;

  typedef struct packed {
    logic        set;
    pc_sel_e     sel;
    exc_pc_sel_e exc_sel;
  } pc_ctrl_t;

  typedef struct packed {
    logic            save_if;       // save pc of IF (irq)
    logic            save_id;       // save pc of ID (exception)
    logic            restore_mret;
    logic            save_cause;
    exc_cause_e      cause;
    logic [XLEN-1:0] mtval;
  } csr_ctrl_t;

  // fast lines actually implemented
  function automatic logic [MAX_FAST_IRQ-1:0] fast_mask(int unsigned num);
    logic [MAX_FAST_IRQ-1:0] m;
    m = '0;
    for (int unsigned i = 0; i < MAX_FAST_IRQ; i++) begin
      m[i] = (i < num);
    end
    return m;
  endfunction

endpackage

//--- ctrl_top.f
ctrl_pkg.sv
ctrl_irq_arbiter.sv
ctrl_exc_cause.sv
ctrl_fsm.sv
ctrl_top.sv
ctrl_top_properties.sv
tb_ctrl_top.sv

//--- ctrl_top.sv
// decode-stage controller top
// connects the irq arbiter, the exception ranker and the state machine
module ctrl_top #(
  parameter int unsigned NUM_FAST_IRQ = 15  // 1 to 16
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_enable_i,
  input  logic                      stall_i,
  input  logic                      instr_valid_i,
  input  ctrl_pkg::decode_info_t    dec_i,
  input  logic                      load_err_i,
  input  logic                      store_err_i,
  input  logic [ctrl_pkg::XLEN-1:0] lsu_addr_i,
  input  logic                      branch_i,
  input  logic                      jump_i,
  input  ctrl_pkg::irq_info_t       irq_i,
  output ctrl_pkg::pc_ctrl_t        pc_o,
  output ctrl_pkg::csr_ctrl_t       csr_o,
  output logic                      instr_req_o,
  output logic                      busy_o,
  output logic                      first_fetch_o,
  output logic                      id_ready_o,
  output logic                      instr_clear_o
);

  logic                      take_irq;
  ctrl_pkg::exc_cause_e      irq_cause;
  logic                      nmi_mode;
  logic                      exc_req;
  ctrl_pkg::exc_cause_e      exc_cause;
  logic [ctrl_pkg::XLEN-1:0] exc_mtval;
  logic                      load_err_q;
  logic                      store_err_q;
  logic                      any_irq;

  // wake-up from sleep, pending regardless of mie
  assign any_irq = irq_i.nmi | irq_i.msip | irq_i.mtip | irq_i.meip |
                   (|(irq_i.fast & ctrl_pkg::fast_mask(NUM_FAST_IRQ)));

  ctrl_irq_arbiter #(
    .NUM_FAST_IRQ (NUM_FAST_IRQ)
  ) irq_arb0 (
    .irq_i       (irq_i),
    .nmi_mode_i  (nmi_mode),
    .take_irq_o  (take_irq),
    .irq_cause_o (irq_cause)
  );

  ctrl_exc_cause exc0 (
    .dec_i       (dec_i),
    .load_err_i  (load_err_q),
    .store_err_i (store_err_q),
    .lsu_addr_i  (lsu_addr_i),
    .exc_req_o   (exc_req),
    .exc_cause_o (exc_cause),
    .exc_mtval_o (exc_mtval)
  );

  ctrl_fsm fsm0 (
    .clk_i, .rst_ni, .fetch_enable_i, .instr_valid_i, .dec_i, .stall_i,
    .branch_i, .jump_i, .load_err_i, .store_err_i,
    .any_irq_i     (any_irq),
    .take_irq_i    (take_irq),
    .irq_cause_i   (irq_cause),
    .exc_req_i     (exc_req),
    .exc_cause_i   (exc_cause),
    .exc_mtval_i   (exc_mtval),
    .nmi_mode_o    (nmi_mode),
    .load_err_q_o  (load_err_q),
    .store_err_q_o (store_err_q),
    .pc_o, .csr_o, .instr_req_o, .busy_o, .first_fetch_o, .id_ready_o, .instr_clear_o
  );

endmodule

//--- ctrl_top_properties.sv
// controller assertions
// redirect/cause pairing, stall handshake and sleep signalling
module ctrl_top_properties (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                stall_i,
  input logic                id_ready_i,
  input logic                busy_i,
  input logic                instr_req_i,
  input ctrl_pkg::pc_ctrl_t  pc_i,
  input ctrl_pkg::csr_ctrl_t csr_i
);

  // trap redirect always writes mcause
  exc_redirect_saves_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pc_i.set && pc_i.sel == ctrl_pkg::PC_EXC) |-> csr_i.save_cause)
    else $error("trap redirect without cause save");

  // no instr consumed under back-pressure
  no_ready_in_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i |-> !id_ready_i)
    else $error("id_ready_o high while stall_i high");

  // idle only while asleep, fetch is off then
  idle_only_asleep: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_i |-> !instr_req_i)
    else $error("busy_o low while fetch still requested");

endmodule

//--- run.sh
#!/bin/sh
# build the controller testbench with verilator, run it, look for the pass line
verilator --binary --assert --top-module tb_ctrl_top -f ctrl_top.f -o sim_ctrl_top &&
  out=$(./obj_dir/sim_ctrl_top) &&
  echo "$out" &&
  echo "$out" | grep -q "TESTBENCH PASSED" &&
  echo "run ok" ||
  { echo "run failed"; exit 1; }

//--- tb_ctrl_top.sv
// testbench for the decode-stage controller
// boot, exception ranking, lsu faults, interrupts, mret, stall and wfi
module tb_ctrl_top;

  localparam int MT_ZERO  = 0;  // expected mtval kinds
  localparam int MT_PC    = 1;
  localparam int MT_INSTR = 2;
  localparam int MT_LSU   = 3;
  localparam int EV_BOOT  = 0;  // things to wait for
  localparam int EV_FIRST = 1;
  localparam int EV_BUSY  = 2;
  localparam int EV_IDLE  = 3;
  localparam int TIMEOUT  = 20;

  typedef struct packed {
    ctrl_pkg::decode_info_t dec;
    logic                   branch;
    logic                   load_err;
    logic                   store_err;
    logic [31:0]            lsu_addr;
    ctrl_pkg::irq_info_t    irq;
    ctrl_pkg::pc_sel_e      exp_sel;
    logic [5:0]             exp_cause;
    logic [31:0]            exp_mtval;
  } entry_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      fetch_enable_i;
  logic                      stall_i;
  logic                      instr_valid_i;
  ctrl_pkg::decode_info_t    dec_i;
  logic                      load_err_i;
  logic                      store_err_i;
  logic [ctrl_pkg::XLEN-1:0] lsu_addr_i;
  logic                      branch_i;
  logic                      jump_i;
  ctrl_pkg::irq_info_t       irq_i;
  ctrl_pkg::pc_ctrl_t        pc_o;
  ctrl_pkg::csr_ctrl_t       csr_o;
  logic                      instr_req_o;
  logic                      busy_o;
  logic                      first_fetch_o;
  logic                      id_ready_o;
  logic                      instr_clear_o;

  entry_t      tbl[$];
  entry_t      e;
  logic [31:0] rng;  // xorshift state
  int          mismatches;
  int          timeouts;

  ctrl_top #(.NUM_FAST_IRQ(15)) dut0 (.*);  // line 15 not implemented

  bind ctrl_top ctrl_top_properties props0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall_i),
    .id_ready_i  (id_ready_o),
    .busy_i      (busy_o),
    .instr_req_i (instr_req_o),
    .pc_i        (pc_o),
    .csr_i       (csr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // flags: illegal ecall ebrk mret wfi fetch_err compressed
  // errs: store load, irqs: nmi msip mtip meip mie
  function automatic entry_t make_entry(input logic [6:0] flags, input logic [1:0] errs,
                                        input logic br, input logic [4:0] irqs,
                                        input logic [15:0] fast, input ctrl_pkg::pc_sel_e sel,
                                        input logic [5:0] cause, input int mt);
    entry_t r;
    r = '0;
    rng = xorshift(rng);
    r.dec.pc = rng;
    rng = xorshift(rng);
    r.dec.instr = rng;
    rng = xorshift(rng);
    r.dec.instr_c = rng[15:0];
    rng = xorshift(rng);
    r.lsu_addr = rng;
    {r.dec.illegal, r.dec.ecall, r.dec.ebrk, r.dec.mret, r.dec.wfi, r.dec.fetch_err,
     r.dec.is_compressed} = flags;
    {r.store_err, r.load_err} = errs;
    r.branch = br;
    {r.irq.nmi, r.irq.msip, r.irq.mtip, r.irq.meip, r.irq.mie} = irqs;
    r.irq.fast = fast;
    r.exp_sel = sel;
    r.exp_cause = cause;
    case (mt)
      MT_PC:    r.exp_mtval = r.dec.pc;
      MT_INSTR: r.exp_mtval = r.dec.is_compressed ? {16'h0, r.dec.instr_c} : r.dec.instr;
      MT_LSU:   r.exp_mtval = r.lsu_addr;
      default:  r.exp_mtval = '0;
    endcase
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic clear_inputs();
    instr_valid_i <= 1'b0;
    dec_i         <= '0;
    branch_i      <= 1'b0;
    load_err_i    <= 1'b0;
    store_err_i   <= 1'b0;
    stall_i       <= 1'b0;
    irq_i         <= '0;
  endtask

  // polls at falling edges, outputs settled there
  task automatic wait_event(input int kind, input string what);
    int   n;
    logic hit;
    n = 0;
    hit = 1'b0;
    while (!hit && n < TIMEOUT) begin
      @(negedge clk_i);
      case (kind)
        EV_BOOT:  hit = pc_o.set & instr_req_o;
        EV_FIRST: hit = first_fetch_o;
        EV_BUSY:  hit = busy_o;
        default:  hit = ~busy_o;
      endcase
      n++;
    end
    if (!hit) begin
      timeouts++;
      $display("timeout at %0t: %s never happened", $time, what);
    end
  endtask

  task automatic apply_entry(input int idx, input entry_t t);
    int   n;
    logic hit;
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    dec_i         <= t.dec;
    branch_i      <= t.branch;
    load_err_i    <= t.load_err;
    store_err_i   <= t.store_err;
    lsu_addr_i    <= t.lsu_addr;
    irq_i         <= t.irq;
    n = 0;
    hit = 1'b0;
    while (!hit && n < TIMEOUT) begin
      @(negedge clk_i);
      hit = pc_o.set;
      if (!hit) begin
        @(posedge clk_i);
        load_err_i  <= 1'b0;  // one-cycle pulses
        store_err_i <= 1'b0;
        n++;
      end
    end
    if (!hit) begin
      timeouts++;
      $display("timeout at %0t: entry %0d gave no pc redirect", $time, idx);
    end else begin
      check_value($sformatf("entry %0d pc sel", idx), 32'(pc_o.sel), 32'(t.exp_sel));
      check_value($sformatf("entry %0d exc sel", idx), 32'(pc_o.exc_sel),
                  32'(t.exp_cause[5]));  // irq vector for irq causes
      check_value($sformatf("entry %0d cause", idx), 32'(csr_o.cause), 32'(t.exp_cause));
      check_value($sformatf("entry %0d mtval", idx), csr_o.mtval, t.exp_mtval);
      check_value($sformatf("entry %0d restore_mret", idx), 32'(csr_o.restore_mret),
                  32'(t.exp_sel == ctrl_pkg::PC_ERET));
      check_value($sformatf("entry %0d save_cause", idx), 32'(csr_o.save_cause),
                  32'(t.exp_sel == ctrl_pkg::PC_EXC));
      check_value($sformatf("entry %0d save_if", idx), 32'(csr_o.save_if),
                  32'(t.exp_sel == ctrl_pkg::PC_EXC && t.exp_cause[5]));  // irq saves IF pc
      check_value($sformatf("entry %0d save_id", idx), 32'(csr_o.save_id),
                  32'(t.exp_sel == ctrl_pkg::PC_EXC && !t.exp_cause[5]));
    end
    @(posedge clk_i);
    clear_inputs();
    repeat (2) @(posedge clk_i);  // idle gap
  endtask

  initial begin
    rng            = 32'd42;
    mismatches     = 0;
    timeouts       = 0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    stall_i        = 1'b0;
    instr_valid_i  = 1'b0;
    dec_i          = '0;
    load_err_i     = 1'b0;
    store_err_i    = 1'b0;
    lsu_addr_i     = '0;
    branch_i       = 1'b0;
    jump_i         = 1'b0;
    irq_i          = '0;

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////
    tbl.push_back(make_entry(7'b1010010, 2'b00, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::INSTR_ACCESS_FAULT, MT_PC));    // fetch beats all
    tbl.push_back(make_entry(7'b1100000, 2'b00, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::ILLEGAL_INSN, MT_INSTR));
    tbl.push_back(make_entry(7'b1000001, 2'b00, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::ILLEGAL_INSN, MT_INSTR));       // compressed
    tbl.push_back(make_entry(7'b0110000, 2'b00, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::ECALL_MMODE, MT_ZERO));
    tbl.push_back(make_entry(7'b0010000, 2'b00, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::BREAKPOINT, MT_ZERO));
    tbl.push_back(make_entry(7'b0000000, 2'b11, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::STORE_ACCESS_FAULT, MT_LSU));   // store over load
    tbl.push_back(make_entry(7'b0000000, 2'b01, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::LOAD_ACCESS_FAULT, MT_LSU));
    tbl.push_back(make_entry(7'b0000000, 2'b00, 1'b0, 5'b11000, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::IRQ_NM, MT_ZERO));              // nmi, mie clear
    tbl.push_back(make_entry(7'b0001000, 2'b00, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_ERET,
                             6'd0, MT_ZERO));                          // leaves nmi mode
    tbl.push_back(make_entry(7'b0000000, 2'b00, 1'b0, 5'b00011, 16'hC001, ctrl_pkg::PC_EXC,
                             6'd62, MT_ZERO));                         // fast 14, 15 absent
    tbl.push_back(make_entry(7'b0000000, 2'b00, 1'b0, 5'b01111, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::IRQ_EXTERNAL_M, MT_ZERO));
    tbl.push_back(make_entry(7'b0000000, 2'b00, 1'b0, 5'b01101, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::IRQ_SOFTWARE_M, MT_ZERO));
    tbl.push_back(make_entry(7'b0000000, 2'b00, 1'b0, 5'b00101, 16'h0, ctrl_pkg::PC_EXC,
                             ctrl_pkg::IRQ_TIMER_M, MT_ZERO));
    tbl.push_back(make_entry(7'b0000000, 2'b00, 1'b1, 5'b00000, 16'h0, ctrl_pkg::PC_JUMP,
                             6'd0, MT_ZERO));                          // branch redirect

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("reset busy_o", 32'(busy_o), 32'd1);
    check_value("reset instr_req_o", 32'(instr_req_o), 32'd0);
    check_value("reset pc set", 32'(pc_o.set), 32'd1);
    check_value("reset pc sel", 32'(pc_o.sel), 32'(ctrl_pkg::PC_BOOT));
    check_value("reset csr_o", 32'(|csr_o), 32'd0);

    // boot
    @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    wait_event(EV_BOOT, "boot redirect");
    check_value("boot pc sel", 32'(pc_o.sel), 32'(ctrl_pkg::PC_BOOT));
    wait_event(EV_FIRST, "first fetch");
    wait_event(EV_BUSY, "busy after boot");
    repeat (2) @(posedge clk_i);

    foreach (tbl[i]) apply_entry(i, tbl[i]);

    // stall holds back an illegal instr
    e = make_entry(7'b1000000, 2'b00, 1'b0, 5'b00000, 16'h0, ctrl_pkg::PC_EXC, 6'd2, MT_ZERO);
    @(posedge clk_i);
    stall_i       <= 1'b1;
    instr_valid_i <= 1'b1;
    dec_i         <= e.dec;
    repeat (6) begin
      @(negedge clk_i);
      check_value("id_ready_o in stall", 32'(id_ready_o), 32'd0);
      check_value("pc set in stall", 32'(pc_o.set), 32'd0);
      check_value("instr_clear_o in stall", 32'(instr_clear_o), 32'd0);
    end
    @(posedge clk_i);
    clear_inputs();

    // masked software irq is ignored
    e = make_entry(7'b0000000, 2'b00, 1'b0, 5'b01000, 16'h0, ctrl_pkg::PC_EXC, 6'd0, MT_ZERO);
    @(posedge clk_i);
    irq_i <= e.irq;
    repeat (5) begin
      @(negedge clk_i);
      check_value("pc set on masked irq", 32'(pc_o.set), 32'd0);
    end
    @(posedge clk_i);
    clear_inputs();

    // wfi sleep and wake-up
    e = make_entry(7'b0000100, 2'b00, 1'b0, 5'b01000, 16'h0, ctrl_pkg::PC_EXC, 6'd0, MT_ZERO);
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    dec_i         <= e.dec;
    wait_event(EV_IDLE, "sleep after wfi");
    @(posedge clk_i);
    clear_inputs();
    repeat (4) begin
      @(negedge clk_i);
      check_value("busy_o in sleep", 32'(busy_o), 32'd0);
    end
    @(posedge clk_i);
    irq_i <= e.irq;  // pending but masked, wake only
    wait_event(EV_BUSY, "wake-up from sleep");
    check_value("first_fetch_o on wake-up", 32'(first_fetch_o), 32'd1);
    @(posedge clk_i);
    clear_inputs();
    repeat (3) @(posedge clk_i);

    $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
